/* Makefile */
VERILATOR ?= verilator
TOP ?= icache_lce_cmd_tb
FILELIST ?= icache_lce_cmd.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* icache_lce_cmd.f */
rtl/lce_cmd_pkg.sv
rtl/lce_cmd_decode.sv
rtl/lce_cmd_exec.sv
rtl/lce_cmd_result.sv
rtl/icache_lce_cmd.sv
verification/icache_lce_cmd_chk.sv
verification/icache_lce_cmd_tb.sv

/* rtl/icache_lce_cmd.sv */
module icache_lce_cmd
  import lce_cmd_pkg::*;
#(
  parameter int sets_p = 64,
  parameter int assoc_p = 4,
  parameter int num_cce_p = 2,
  parameter int paddr_width_p = 22,
  parameter int block_width_p = 64,
  parameter int lce_id_width_p = 3,
  localparam int offset_width_lp = $clog2(block_width_p / 8),
  localparam int index_width_lp = $clog2(sets_p),
  localparam int tag_width_lp = paddr_width_p - offset_width_lp - index_width_lp,
  localparam int way_width_lp = $clog2(assoc_p),
  localparam int cnt_width_lp = $clog2((sets_p > num_cce_p) ? sets_p : num_cce_p) + 1
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [lce_id_width_p-1:0]   lce_id_i,
  input  logic [paddr_width_p-1:0]    miss_addr_i,
  input  lce_cmd_type_e               lce_cmd_type_i,
  input  logic [lce_id_width_p-1:0]   lce_cmd_src_id_i,
  input  logic [paddr_width_p-1:0]    lce_cmd_addr_i,
  input  logic [way_width_lp-1:0]     lce_cmd_way_i,
  input  coh_state_e                  lce_cmd_state_i,
  input  logic [block_width_p-1:0]    lce_cmd_data_i,
  input  logic                        lce_cmd_v_i,
  output logic                        lce_cmd_yumi_o,
  output logic [index_width_lp-1:0]   tag_mem_index_o,
  output logic [way_width_lp-1:0]     tag_mem_way_o,
  output logic [tag_width_lp-1:0]     tag_mem_tag_o,
  output coh_state_e                  tag_mem_state_o,
  output tag_mem_op_e                 tag_mem_op_o,
  output logic                        tag_mem_v_o,
  input  logic                        tag_mem_ready_i,
  output logic [index_width_lp-1:0]   stat_mem_index_o,
  output logic                        stat_mem_v_o,
  input  logic                        stat_mem_ready_i,
  output logic [index_width_lp-1:0]   data_mem_index_o,
  output logic [way_width_lp-1:0]     data_mem_way_o,
  output logic [block_width_p-1:0]    data_mem_data_o,
  output data_mem_op_e                data_mem_op_o,
  output logic                        data_mem_v_o,
  input  logic                        data_mem_ready_i,
  output logic [lce_id_width_p-1:0]   lce_resp_src_o,
  output logic [lce_id_width_p-1:0]   lce_resp_dst_o,
  output lce_resp_type_e              lce_resp_type_o,
  output logic [paddr_width_p-1:0]    lce_resp_addr_o,
  output logic                        lce_resp_v_o,
  input  logic                        lce_resp_yumi_i,
  output logic                        lce_ready_o,
  output logic                        set_tag_received_o,
  output logic                        set_tag_wakeup_received_o,
  output logic                        cce_data_received_o,
  output logic                        uncached_data_received_o,
  output logic                        cache_req_complete_o
);

  lce_action_e action;
  logic [index_width_lp-1:0] cmd_index;
  logic [tag_width_lp-1:0] cmd_tag;
  logic ready_mode;
  logic sweep;
  logic [cnt_width_lp-1:0] count;

  lce_cmd_decode #(
    .sets_p(sets_p),
    .paddr_width_p(paddr_width_p),
    .block_width_p(block_width_p)
  ) i_decode (
    .lce_cmd_type_i(lce_cmd_type_i),
    .lce_cmd_addr_i(lce_cmd_addr_i),
    .lce_cmd_v_i(lce_cmd_v_i),
    .ready_mode_i(ready_mode),
    .action_o(action),
    .cmd_index_o(cmd_index),
    .cmd_tag_o(cmd_tag)
  );

  lce_cmd_exec #(
    .sets_p(sets_p),
    .num_cce_p(num_cce_p)
  ) i_exec (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .action_i(action),
    .tag_mem_ready_i(tag_mem_ready_i),
    .stat_mem_ready_i(stat_mem_ready_i),
    .data_mem_ready_i(data_mem_ready_i),
    .lce_resp_yumi_i(lce_resp_yumi_i),
    .ready_mode_o(ready_mode),
    .sweep_o(sweep),
    .count_o(count),
    .tag_mem_v_o(tag_mem_v_o),
    .stat_mem_v_o(stat_mem_v_o),
    .data_mem_v_o(data_mem_v_o),
    .lce_resp_v_o(lce_resp_v_o),
    .lce_cmd_yumi_o(lce_cmd_yumi_o),
    .lce_ready_o(lce_ready_o),
    .set_tag_received_o(set_tag_received_o),
    .set_tag_wakeup_received_o(set_tag_wakeup_received_o),
    .cce_data_received_o(cce_data_received_o),
    .uncached_data_received_o(uncached_data_received_o),
    .cache_req_complete_o(cache_req_complete_o)
  );

  lce_cmd_result #(
    .sets_p(sets_p),
    .assoc_p(assoc_p),
    .num_cce_p(num_cce_p),
    .paddr_width_p(paddr_width_p),
    .block_width_p(block_width_p),
    .lce_id_width_p(lce_id_width_p)
  ) i_result (
    .lce_id_i(lce_id_i),
    .action_i(action),
    .sweep_i(sweep),
    .count_i(count),
    .cmd_index_i(cmd_index),
    .cmd_tag_i(cmd_tag),
    .miss_addr_i(miss_addr_i),
    .lce_cmd_src_id_i(lce_cmd_src_id_i),
    .lce_cmd_addr_i(lce_cmd_addr_i),
    .lce_cmd_way_i(lce_cmd_way_i),
    .lce_cmd_state_i(lce_cmd_state_i),
    .lce_cmd_data_i(lce_cmd_data_i),
    .tag_mem_index_o(tag_mem_index_o),
    .tag_mem_way_o(tag_mem_way_o),
    .tag_mem_tag_o(tag_mem_tag_o),
    .tag_mem_state_o(tag_mem_state_o),
    .tag_mem_op_o(tag_mem_op_o),
    .stat_mem_index_o(stat_mem_index_o),
    .data_mem_index_o(data_mem_index_o),
    .data_mem_way_o(data_mem_way_o),
    .data_mem_data_o(data_mem_data_o),
    .data_mem_op_o(data_mem_op_o),
    .lce_resp_src_o(lce_resp_src_o),
    .lce_resp_dst_o(lce_resp_dst_o),
    .lce_resp_type_o(lce_resp_type_o),
    .lce_resp_addr_o(lce_resp_addr_o)
  );

endmodule

/* rtl/lce_cmd_decode.sv */
module lce_cmd_decode
  import lce_cmd_pkg::*;
#(
  parameter int sets_p = 64,
  parameter int paddr_width_p = 22,
  parameter int block_width_p = 64,
  localparam int offset_width_lp = $clog2(block_width_p / 8),
  localparam int index_width_lp = $clog2(sets_p),
  localparam int tag_width_lp = paddr_width_p - offset_width_lp - index_width_lp
) (
  input  lce_cmd_type_e                lce_cmd_type_i,
  input  logic [paddr_width_p-1:0]     lce_cmd_addr_i,
  input  logic                         lce_cmd_v_i,
  input  logic                         ready_mode_i,
  output lce_action_e                  action_o,
  output logic [index_width_lp-1:0]    cmd_index_o,
  output logic [tag_width_lp-1:0]      cmd_tag_o
);

  lce_action_e full_action;

  assign cmd_index_o = lce_cmd_addr_i[offset_width_lp +: index_width_lp];
  assign cmd_tag_o = lce_cmd_addr_i[offset_width_lp + index_width_lp +: tag_width_lp];

  always_comb begin
    case (lce_cmd_type_i)
      e_cmd_sync:           full_action = act_sync;
      e_cmd_set_clear:      full_action = act_set_clear;
      e_cmd_set_tag:        full_action = act_set_tag;
      e_cmd_set_tag_wakeup: full_action = act_set_tag_wakeup;
      e_cmd_invalidate_tag: full_action = act_invalidate;
      e_cmd_writeback:      full_action = act_writeback;
      e_cmd_data:           full_action = act_data;
      e_cmd_uc_data:        full_action = act_uc_data;
      default:              full_action = act_none;
    endcase
  end

  // filter by mode, sync only matters before ready mode
  always_comb begin
    action_o = act_none;
    if (lce_cmd_v_i) begin
      if (ready_mode_i) begin
        if (full_action != act_sync) begin
          action_o = full_action;
        end
      end else if (full_action inside {act_sync, act_set_clear, act_uc_data}) begin
        action_o = full_action;
      end
    end
  end

endmodule

/* rtl/lce_cmd_exec.sv */
module lce_cmd_exec
  import lce_cmd_pkg::*;
#(
  parameter int sets_p = 64,
  parameter int num_cce_p = 2,
  localparam int cnt_width_lp = $clog2((sets_p > num_cce_p) ? sets_p : num_cce_p) + 1
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  lce_action_e               action_i,
  input  logic                      tag_mem_ready_i,
  input  logic                      stat_mem_ready_i,
  input  logic                      data_mem_ready_i,
  input  logic                      lce_resp_yumi_i,
  output logic                      ready_mode_o,
  output logic                      sweep_o,
  output logic [cnt_width_lp-1:0]   count_o,
  output logic                      tag_mem_v_o,
  output logic                      stat_mem_v_o,
  output logic                      data_mem_v_o,
  output logic                      lce_resp_v_o,
  output logic                      lce_cmd_yumi_o,
  output logic                      lce_ready_o,
  output logic                      set_tag_received_o,
  output logic                      set_tag_wakeup_received_o,
  output logic                      cce_data_received_o,
  output logic                      uncached_data_received_o,
  output logic                      cache_req_complete_o
);

  typedef enum logic [1:0] {
    e_state_sweep,
    e_state_uc_only,
    e_state_ready
  } exec_state_e;

  exec_state_e state_r, state_n;
  logic [cnt_width_lp-1:0] cnt_r, cnt_n;
  logic inv_pending_r, inv_pending_n;
  logic clear_ready;
  logic fill_ready;

  // clears need tag and stat together, fills need tag and data together
  assign clear_ready = tag_mem_ready_i & stat_mem_ready_i;
  assign fill_ready = tag_mem_ready_i & data_mem_ready_i;

  assign sweep_o = (state_r == e_state_sweep);
  assign ready_mode_o = (state_r == e_state_ready);
  assign lce_ready_o = (state_r != e_state_sweep);
  assign count_o = cnt_r;

  always_comb begin
    state_n = state_r;
    cnt_n = cnt_r;
    inv_pending_n = inv_pending_r;
    tag_mem_v_o = 1'b0;
    stat_mem_v_o = 1'b0;
    data_mem_v_o = 1'b0;
    lce_resp_v_o = 1'b0;
    lce_cmd_yumi_o = 1'b0;
    set_tag_received_o = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o = 1'b0;
    uncached_data_received_o = 1'b0;
    cache_req_complete_o = 1'b0;

    if (state_r == e_state_sweep) begin
      // counter walks the sets, commands wait until the sweep is over
      tag_mem_v_o = clear_ready;
      stat_mem_v_o = clear_ready;
      if (clear_ready) begin
        if (cnt_r == cnt_width_lp'(sets_p - 1)) begin
          state_n = e_state_uc_only;
          cnt_n = '0;
        end else begin
          cnt_n = cnt_r + 1'b1;
        end
      end
    end else begin
      case (action_i)
        act_sync: begin
          lce_resp_v_o = 1'b1;
          lce_cmd_yumi_o = lce_resp_yumi_i;
          // counter now tallies accepted sync acks
          if (lce_resp_yumi_i) begin
            if (cnt_r == cnt_width_lp'(num_cce_p - 1)) begin
              state_n = e_state_ready;
              cnt_n = '0;
            end else begin
              cnt_n = cnt_r + 1'b1;
            end
          end
        end
        act_set_clear: begin
          tag_mem_v_o = clear_ready;
          stat_mem_v_o = clear_ready;
          lce_cmd_yumi_o = clear_ready;
        end
        act_set_tag: begin
          tag_mem_v_o = tag_mem_ready_i;
          lce_cmd_yumi_o = tag_mem_ready_i;
          set_tag_received_o = tag_mem_ready_i;
        end
        act_set_tag_wakeup: begin
          tag_mem_v_o = tag_mem_ready_i;
          lce_cmd_yumi_o = tag_mem_ready_i;
          set_tag_wakeup_received_o = tag_mem_ready_i;
          cache_req_complete_o = tag_mem_ready_i;
        end
        act_invalidate: begin
          // tag write goes out once, then the ack waits for yumi
          tag_mem_v_o = ~inv_pending_r & tag_mem_ready_i;
          lce_resp_v_o = inv_pending_r | tag_mem_v_o;
          lce_cmd_yumi_o = lce_resp_v_o & lce_resp_yumi_i;
          inv_pending_n = lce_resp_v_o & ~lce_resp_yumi_i;
        end
        act_writeback: begin
          lce_resp_v_o = 1'b1;
          lce_cmd_yumi_o = lce_resp_yumi_i;
        end
        act_data: begin
          tag_mem_v_o = fill_ready;
          data_mem_v_o = fill_ready;
          lce_cmd_yumi_o = fill_ready;
          cce_data_received_o = fill_ready;
          set_tag_received_o = fill_ready;
          cache_req_complete_o = fill_ready;
        end
        act_uc_data: begin
          data_mem_v_o = data_mem_ready_i;
          lce_cmd_yumi_o = data_mem_ready_i;
          uncached_data_received_o = data_mem_ready_i;
          cache_req_complete_o = data_mem_ready_i;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_state_sweep;
      cnt_r <= '0;
      inv_pending_r <= 1'b0;
    end else begin
      state_r <= state_n;
      cnt_r <= cnt_n;
      inv_pending_r <= inv_pending_n;
    end
  end

endmodule

/* rtl/lce_cmd_pkg.sv */
package lce_cmd_pkg;

  // commands arriving from the directory
  typedef enum logic [3:0] {
    e_cmd_sync,
    e_cmd_set_clear,
    e_cmd_set_tag,
    e_cmd_set_tag_wakeup,
    e_cmd_invalidate_tag,
    e_cmd_writeback,
    e_cmd_data,
    e_cmd_uc_data
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_null_wb
  } lce_resp_type_e;

  typedef enum logic [2:0] {
    e_coh_i,
    e_coh_s,
    e_coh_e,
    e_coh_m
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_clear,
    e_tag_set,
    e_tag_invalidate
  } tag_mem_op_e;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_mem_op_e;

  // decoded work item, act_none when nothing legal is pending
  typedef enum logic [3:0] {
    act_none, act_sync, act_set_clear, act_set_tag, act_set_tag_wakeup,
    act_invalidate, act_writeback, act_data, act_uc_data
  } lce_action_e;

endpackage

/* rtl/lce_cmd_result.sv */
module lce_cmd_result
  import lce_cmd_pkg::*;
#(
  parameter int sets_p = 64,
  parameter int assoc_p = 4,
  parameter int num_cce_p = 2,
  parameter int paddr_width_p = 22,
  parameter int block_width_p = 64,
  parameter int lce_id_width_p = 3,
  localparam int offset_width_lp = $clog2(block_width_p / 8),
  localparam int index_width_lp = $clog2(sets_p),
  localparam int tag_width_lp = paddr_width_p - offset_width_lp - index_width_lp,
  localparam int way_width_lp = $clog2(assoc_p),
  localparam int cnt_width_lp = $clog2((sets_p > num_cce_p) ? sets_p : num_cce_p) + 1
) (
  input  logic [lce_id_width_p-1:0]   lce_id_i,
  input  lce_action_e                 action_i,
  input  logic                        sweep_i,
  input  logic [cnt_width_lp-1:0]     count_i,
  input  logic [index_width_lp-1:0]   cmd_index_i,
  input  logic [tag_width_lp-1:0]     cmd_tag_i,
  input  logic [paddr_width_p-1:0]    miss_addr_i,
  input  logic [lce_id_width_p-1:0]   lce_cmd_src_id_i,
  input  logic [paddr_width_p-1:0]    lce_cmd_addr_i,
  input  logic [way_width_lp-1:0]     lce_cmd_way_i,
  input  coh_state_e                  lce_cmd_state_i,
  input  logic [block_width_p-1:0]    lce_cmd_data_i,
  output logic [index_width_lp-1:0]   tag_mem_index_o,
  output logic [way_width_lp-1:0]     tag_mem_way_o,
  output logic [tag_width_lp-1:0]     tag_mem_tag_o,
  output coh_state_e                  tag_mem_state_o,
  output tag_mem_op_e                 tag_mem_op_o,
  output logic [index_width_lp-1:0]   stat_mem_index_o,
  output logic [index_width_lp-1:0]   data_mem_index_o,
  output logic [way_width_lp-1:0]     data_mem_way_o,
  output logic [block_width_p-1:0]    data_mem_data_o,
  output data_mem_op_e                data_mem_op_o,
  output logic [lce_id_width_p-1:0]   lce_resp_src_o,
  output logic [lce_id_width_p-1:0]   lce_resp_dst_o,
  output lce_resp_type_e              lce_resp_type_o,
  output logic [paddr_width_p-1:0]    lce_resp_addr_o
);

  logic [index_width_lp-1:0] index;
  logic fill;
  logic set_tag;

  // fills land in the set of the outstanding miss
  assign fill = (action_i == act_data) | (action_i == act_uc_data);
  assign set_tag = ~sweep_i & (action_i inside {act_set_tag, act_set_tag_wakeup, act_data});

  assign index = sweep_i ? count_i[index_width_lp-1:0]
               : fill ? miss_addr_i[offset_width_lp +: index_width_lp]
               : cmd_index_i;

  assign tag_mem_index_o = index;
  assign tag_mem_way_o = sweep_i ? '0 : lce_cmd_way_i;
  assign tag_mem_tag_o = set_tag ? cmd_tag_i : '0;
  assign tag_mem_state_o = set_tag ? lce_cmd_state_i : e_coh_i;
  assign tag_mem_op_o = set_tag ? e_tag_set
                      : (~sweep_i & (action_i == act_invalidate)) ? e_tag_invalidate
                      : e_tag_clear;

  assign stat_mem_index_o = index;

  assign data_mem_index_o = index;
  assign data_mem_way_o = lce_cmd_way_i;
  assign data_mem_data_o = lce_cmd_data_i;
  assign data_mem_op_o = (action_i == act_uc_data) ? e_data_uncached : e_data_write;

  assign lce_resp_src_o = lce_id_i;
  assign lce_resp_dst_o = lce_cmd_src_id_i;

  always_comb begin
    lce_resp_type_o = e_resp_sync_ack;
    lce_resp_addr_o = '0;
    if (action_i == act_invalidate) begin
      lce_resp_type_o = e_resp_inv_ack;
      lce_resp_addr_o = lce_cmd_addr_i;
    end else if (action_i == act_writeback) begin
      lce_resp_type_o = e_resp_null_wb;
      lce_resp_addr_o = lce_cmd_addr_i;
    end
  end

endmodule

/* verification/icache_lce_cmd_chk.sv */
module icache_lce_cmd_chk (
  input logic clk_i,
  input logic reset_i,
  input logic tag_mem_v_i,
  input logic tag_mem_ready_i,
  input logic stat_mem_v_i,
  input logic stat_mem_ready_i,
  input logic data_mem_v_i,
  input logic data_mem_ready_i,
  input logic lce_cmd_v_i,
  input logic lce_cmd_yumi_i,
  input logic lce_ready_i
);

  // a packet valid only goes up while its sink is ready
  valid_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    !(tag_mem_v_i && !tag_mem_ready_i) && !(stat_mem_v_i && !stat_mem_ready_i)
    && !(data_mem_v_i && !data_mem_ready_i))
    else $error("memory packet valid while its ready is low");

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_yumi_i |-> lce_cmd_v_i)
    else $error("command yumi without a valid command");

  // once the sweep is over the agent never leaves service
  ready_stays_high: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_ready_i |=> lce_ready_i)
    else $error("lce_ready_o dropped after it was raised");

endmodule

/* verification/icache_lce_cmd_tb.sv */
module icache_lce_cmd_tb
  import lce_cmd_pkg::*;
();

  localparam int sets_lp = 64;
  localparam int assoc_lp = 4;
  localparam int num_cce_lp = 2;
  localparam int paddr_width_lp = 22;
  localparam int block_width_lp = 64;
  localparam int id_width_lp = 3;
  localparam int offset_width_lp = $clog2(block_width_lp / 8);
  localparam int index_width_lp = $clog2(sets_lp);
  localparam int tag_width_lp = paddr_width_lp - offset_width_lp - index_width_lp;
  localparam int way_width_lp = $clog2(assoc_lp);
  localparam int num_rows_lp = 14;
  localparam int timeout_lp = sets_lp + num_rows_lp * 8;

  // which consumer holds back during a row
  localparam logic [1:0] st_none = 2'd0;
  localparam logic [1:0] st_tag = 2'd1;
  localparam logic [1:0] st_yumi = 2'd2;
  localparam logic [1:0] st_data = 2'd3;

  typedef struct {
    lce_cmd_type_e typ;
    logic [1:0] stall;
    int hold;
    logic accept;
    logic exp_tag;
    tag_mem_op_e exp_tag_op;
    logic exp_stat;
    logic exp_data;
    data_mem_op_e exp_data_op;
    logic exp_resp;
    lce_resp_type_e exp_resp_type;
    logic use_miss;
    logic [4:0] exp_pulses;
  } row_t;

  row_t rows [num_rows_lp];
  int n_rows = 0;
  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  logic [31:0] lcg_state = 32'd59338;

  logic clk = 1'b0;
  logic reset;
  logic [id_width_lp-1:0] lce_id;
  logic [paddr_width_lp-1:0] miss_addr;
  lce_cmd_type_e cmd_type;
  logic [id_width_lp-1:0] cmd_src_id;
  logic [paddr_width_lp-1:0] cmd_addr;
  logic [way_width_lp-1:0] cmd_way;
  coh_state_e cmd_state;
  logic [block_width_lp-1:0] cmd_data;
  logic cmd_v;
  logic cmd_yumi;
  logic [index_width_lp-1:0] tag_index;
  logic [way_width_lp-1:0] tag_way;
  logic [tag_width_lp-1:0] tag_tag;
  coh_state_e tag_state;
  tag_mem_op_e tag_op;
  logic tag_v;
  logic tag_ready;
  logic [index_width_lp-1:0] stat_index;
  logic stat_v;
  logic stat_ready;
  logic [index_width_lp-1:0] data_index;
  logic [way_width_lp-1:0] data_way;
  logic [block_width_lp-1:0] data_data;
  data_mem_op_e data_op;
  logic data_v;
  logic data_ready;
  logic [id_width_lp-1:0] resp_src;
  logic [id_width_lp-1:0] resp_dst;
  lce_resp_type_e resp_type;
  logic [paddr_width_lp-1:0] resp_addr;
  logic resp_v;
  logic resp_yumi;
  logic lce_ready;
  logic set_tag_pulse;
  logic wakeup_pulse;
  logic fill_pulse;
  logic uc_pulse;
  logic complete_pulse;

  // last packet taken by each memory sink
  int tag_count = 0;
  int stat_count = 0;
  int data_count = 0;
  logic [index_width_lp-1:0] sink_tag_index;
  logic [way_width_lp-1:0] sink_tag_way;
  logic [tag_width_lp-1:0] sink_tag_tag;
  coh_state_e sink_tag_state;
  tag_mem_op_e sink_tag_op;
  logic [index_width_lp-1:0] sink_stat_index;
  logic [index_width_lp-1:0] sink_data_index;
  logic [way_width_lp-1:0] sink_data_way;
  logic [block_width_lp-1:0] sink_data_data;
  data_mem_op_e sink_data_op;

  icache_lce_cmd #(
    .sets_p(sets_lp),
    .assoc_p(assoc_lp),
    .num_cce_p(num_cce_lp),
    .paddr_width_p(paddr_width_lp),
    .block_width_p(block_width_lp),
    .lce_id_width_p(id_width_lp)
  ) i_icache_lce_cmd (
    .clk_i(clk),
    .reset_i(reset),
    .lce_id_i(lce_id),
    .miss_addr_i(miss_addr),
    .lce_cmd_type_i(cmd_type),
    .lce_cmd_src_id_i(cmd_src_id),
    .lce_cmd_addr_i(cmd_addr),
    .lce_cmd_way_i(cmd_way),
    .lce_cmd_state_i(cmd_state),
    .lce_cmd_data_i(cmd_data),
    .lce_cmd_v_i(cmd_v),
    .lce_cmd_yumi_o(cmd_yumi),
    .tag_mem_index_o(tag_index),
    .tag_mem_way_o(tag_way),
    .tag_mem_tag_o(tag_tag),
    .tag_mem_state_o(tag_state),
    .tag_mem_op_o(tag_op),
    .tag_mem_v_o(tag_v),
    .tag_mem_ready_i(tag_ready),
    .stat_mem_index_o(stat_index),
    .stat_mem_v_o(stat_v),
    .stat_mem_ready_i(stat_ready),
    .data_mem_index_o(data_index),
    .data_mem_way_o(data_way),
    .data_mem_data_o(data_data),
    .data_mem_op_o(data_op),
    .data_mem_v_o(data_v),
    .data_mem_ready_i(data_ready),
    .lce_resp_src_o(resp_src),
    .lce_resp_dst_o(resp_dst),
    .lce_resp_type_o(resp_type),
    .lce_resp_addr_o(resp_addr),
    .lce_resp_v_o(resp_v),
    .lce_resp_yumi_i(resp_yumi),
    .lce_ready_o(lce_ready),
    .set_tag_received_o(set_tag_pulse),
    .set_tag_wakeup_received_o(wakeup_pulse),
    .cce_data_received_o(fill_pulse),
    .uncached_data_received_o(uc_pulse),
    .cache_req_complete_o(complete_pulse)
  );

  bind icache_lce_cmd icache_lce_cmd_chk i_chk (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .tag_mem_v_i(tag_mem_v_o),
    .tag_mem_ready_i(tag_mem_ready_i),
    .stat_mem_v_i(stat_mem_v_o),
    .stat_mem_ready_i(stat_mem_ready_i),
    .data_mem_v_i(data_mem_v_o),
    .data_mem_ready_i(data_mem_ready_i),
    .lce_cmd_v_i(lce_cmd_v_i),
    .lce_cmd_yumi_i(lce_cmd_yumi_o),
    .lce_ready_i(lce_ready_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (tag_v && tag_ready) begin
      tag_count <= tag_count + 1;
      sink_tag_index <= tag_index;
      sink_tag_way <= tag_way;
      sink_tag_tag <= tag_tag;
      sink_tag_state <= tag_state;
      sink_tag_op <= tag_op;
    end
    if (stat_v && stat_ready) begin
      stat_count <= stat_count + 1;
      sink_stat_index <= stat_index;
    end
    if (data_v && data_ready) begin
      data_count <= data_count + 1;
      sink_data_index <= data_index;
      sink_data_way <= data_way;
      sink_data_data <= data_data;
      sink_data_op <= data_op;
    end
  end

  initial begin
    while (cycle_count < timeout_lp) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles, a command was never finished", timeout_lp);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s = %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  task automatic add_row(input lce_cmd_type_e typ, input logic [1:0] stall, input int hold,
                         input logic accept, input logic exp_tag, input tag_mem_op_e tag_op_e,
                         input logic exp_stat, input logic exp_data,
                         input data_mem_op_e data_op_e, input logic exp_resp,
                         input lce_resp_type_e resp_type_e, input logic use_miss,
                         input logic [4:0] pulses);
    rows[n_rows].typ = typ;
    rows[n_rows].stall = stall;
    rows[n_rows].hold = hold;
    rows[n_rows].accept = accept;
    rows[n_rows].exp_tag = exp_tag;
    rows[n_rows].exp_tag_op = tag_op_e;
    rows[n_rows].exp_stat = exp_stat;
    rows[n_rows].exp_data = exp_data;
    rows[n_rows].exp_data_op = data_op_e;
    rows[n_rows].exp_resp = exp_resp;
    rows[n_rows].exp_resp_type = resp_type_e;
    rows[n_rows].use_miss = use_miss;
    rows[n_rows].exp_pulses = pulses;
    n_rows++;
  endtask

  // pulses are {set_tag, wakeup, cce_data, uncached, complete}
  task automatic build_table();
    // uncached-only mode
    add_row(e_cmd_set_tag, st_none, 3, 0, 0, e_tag_clear, 0, 0, e_data_write, 0,
            e_resp_sync_ack, 0, 5'b00000);
    add_row(e_cmd_set_clear, st_none, 0, 1, 1, e_tag_clear, 1, 0, e_data_write, 0,
            e_resp_sync_ack, 0, 5'b00000);
    add_row(e_cmd_uc_data, st_none, 0, 1, 0, e_tag_clear, 0, 1, e_data_uncached, 0,
            e_resp_sync_ack, 1, 5'b00011);
    add_row(e_cmd_sync, st_none, 0, 1, 0, e_tag_clear, 0, 0, e_data_write, 1,
            e_resp_sync_ack, 0, 5'b00000);
    add_row(e_cmd_sync, st_none, 0, 1, 0, e_tag_clear, 0, 0, e_data_write, 1,
            e_resp_sync_ack, 0, 5'b00000);
    // ready mode
    add_row(e_cmd_set_tag, st_none, 0, 1, 1, e_tag_set, 0, 0, e_data_write, 0,
            e_resp_sync_ack, 0, 5'b10000);
    add_row(e_cmd_set_tag_wakeup, st_none, 0, 1, 1, e_tag_set, 0, 0, e_data_write, 0,
            e_resp_sync_ack, 0, 5'b01001);
    add_row(e_cmd_data, st_none, 0, 1, 1, e_tag_set, 0, 1, e_data_write, 0,
            e_resp_sync_ack, 1, 5'b10101);
    add_row(e_cmd_writeback, st_none, 0, 1, 0, e_tag_clear, 0, 0, e_data_write, 1,
            e_resp_null_wb, 0, 5'b00000);
    add_row(e_cmd_invalidate_tag, st_yumi, 3, 1, 1, e_tag_invalidate, 0, 0, e_data_write, 1,
            e_resp_inv_ack, 0, 5'b00000);
    // back-pressure from the memory sinks
    add_row(e_cmd_set_tag, st_tag, 3, 1, 1, e_tag_set, 0, 0, e_data_write, 0,
            e_resp_sync_ack, 0, 5'b10000);
    add_row(e_cmd_uc_data, st_data, 2, 1, 0, e_tag_clear, 0, 1, e_data_uncached, 0,
            e_resp_sync_ack, 1, 5'b00011);
    add_row(e_cmd_data, st_data, 2, 1, 1, e_tag_set, 0, 1, e_data_write, 0,
            e_resp_sync_ack, 1, 5'b10101);
    add_row(e_cmd_set_clear, st_tag, 1, 1, 1, e_tag_clear, 1, 0, e_data_write, 0,
            e_resp_sync_ack, 0, 5'b00000);
  endtask

  task automatic check_sweep();
    int errors_base;
    errors_base = errors;
    for (int i = 0; i < sets_lp; i++) begin
      @(negedge clk);
      check_value("tag_mem_v_o", 64'(tag_v), 64'd1);
      check_value("stat_mem_v_o", 64'(stat_v), 64'd1);
      check_value("tag_mem_index_o", 64'(tag_index), 64'(i));
      check_value("stat_mem_index_o", 64'(stat_index), 64'(i));
      check_value("tag_mem_op_o", 64'(tag_op), 64'(e_tag_clear));
      check_value("tag_mem_state_o", 64'(tag_state), 64'(e_coh_i));
      check_value("lce_ready_o", 64'(lce_ready), 64'd0);
    end
    @(negedge clk);
    check_value("lce_ready_o", 64'(lce_ready), 64'd1);
    $display("test 0 reset sweep: %s", (errors == errors_base) ? "ok" : "mismatch");
  endtask

  task automatic run_row(input int k);
    row_t r;
    int tag_base;
    int stat_base;
    int data_base;
    int errors_base;
    int waited;
    logic [31:0] rnd;
    logic [index_width_lp-1:0] exp_index;
    r = rows[k];
    tag_base = tag_count;
    stat_base = stat_count;
    data_base = data_count;
    errors_base = errors;
    rnd = lcg_next();
    cmd_addr = {rnd[paddr_width_lp-1:offset_width_lp], {offset_width_lp{1'b0}}};
    rnd = lcg_next();
    miss_addr = rnd[paddr_width_lp-1:0];
    cmd_way = rnd[23:22];
    cmd_src_id = rnd[26:24];
    cmd_state = rnd[28] ? e_coh_m : e_coh_s;
    cmd_data = {lcg_next(), lcg_next()};
    cmd_type = r.typ;
    cmd_v = 1'b1;
    exp_index = r.use_miss ? miss_addr[offset_width_lp +: index_width_lp]
                           : cmd_addr[offset_width_lp +: index_width_lp];
    tag_ready = (r.stall != st_tag);
    data_ready = (r.stall != st_data);
    resp_yumi = (r.stall != st_yumi);
    repeat (r.hold) begin
      @(negedge clk);
      check_cond(!cmd_yumi, "command yumi raised while the command had to wait");
      if (r.stall == st_yumi) begin
        check_cond(resp_v, "response valid dropped before its yumi");
      end else begin
        check_cond(!tag_v && !stat_v && !data_v, "memory packet valid raised without ready");
      end
      @(posedge clk);
      #2;
    end
    tag_ready = 1'b1;
    data_ready = 1'b1;
    resp_yumi = 1'b1;
    if (r.accept) begin
      waited = 0;
      @(negedge clk);
      while (!cmd_yumi) begin
        @(posedge clk);
        #2;
        @(negedge clk);
        waited++;
      end
      check_cond(waited == 0, "command yumi came later than the cycle its consumer was ready");
      check_value("status pulses",
                  64'({set_tag_pulse, wakeup_pulse, fill_pulse, uc_pulse, complete_pulse}),
                  64'(r.exp_pulses));
      check_value("lce_resp_v_o", 64'(resp_v), 64'(r.exp_resp));
      if (r.exp_resp) begin
        check_value("lce_resp_type_o", 64'(resp_type), 64'(r.exp_resp_type));
        check_value("lce_resp_dst_o", 64'(resp_dst), 64'(cmd_src_id));
        check_value("lce_resp_src_o", 64'(resp_src), 64'(lce_id));
        if (r.exp_resp_type != e_resp_sync_ack) begin
          check_value("lce_resp_addr_o", 64'(resp_addr), 64'(cmd_addr));
        end
      end
      @(posedge clk);
      #2;
    end
    cmd_v = 1'b0;
    check_value("tag packet count", 64'(tag_count - tag_base), 64'(r.exp_tag));
    check_value("stat packet count", 64'(stat_count - stat_base), 64'(r.exp_stat));
    check_value("data packet count", 64'(data_count - data_base), 64'(r.exp_data));
    if (r.exp_tag) begin
      check_value("tag_mem_op_o", 64'(sink_tag_op), 64'(r.exp_tag_op));
      check_value("tag_mem_index_o", 64'(sink_tag_index), 64'(exp_index));
      if (r.exp_tag_op == e_tag_set) begin
        check_value("tag_mem_tag_o", 64'(sink_tag_tag),
                    64'(cmd_addr[paddr_width_lp-1 -: tag_width_lp]));
        check_value("tag_mem_state_o", 64'(sink_tag_state), 64'(cmd_state));
        check_value("tag_mem_way_o", 64'(sink_tag_way), 64'(cmd_way));
      end
    end
    if (r.exp_stat) begin
      check_value("stat_mem_index_o", 64'(sink_stat_index), 64'(exp_index));
    end
    if (r.exp_data) begin
      check_value("data_mem_op_o", 64'(sink_data_op), 64'(r.exp_data_op));
      check_value("data_mem_index_o", 64'(sink_data_index), 64'(exp_index));
      check_value("data_mem_way_o", 64'(sink_data_way), 64'(cmd_way));
      check_value("data_mem_data_o", sink_data_data, cmd_data);
    end
    $display("test %0d %s: %s", k + 1, cmd_type.name(), (errors == errors_base) ? "ok" : "mismatch");
  endtask

  initial begin
    reset = 1'b1;
    lce_id = 3'd5;
    miss_addr = '0;
    cmd_type = e_cmd_sync;
    cmd_src_id = '0;
    cmd_addr = '0;
    cmd_way = '0;
    cmd_state = e_coh_i;
    cmd_data = '0;
    cmd_v = 1'b0;
    tag_ready = 1'b1;
    stat_ready = 1'b1;
    data_ready = 1'b1;
    resp_yumi = 1'b1;
    build_table();
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    check_sweep();
    @(posedge clk);
    #2;
    for (int k = 0; k < n_rows; k++) begin
      run_row(k);
    end
    $display("%0d tests, %0d checks, %0d errors", n_rows + 1, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
